// ==== Bender.yml ====
package:
  name: pc_glue

sources:
  - files:
      - src/pc_board_pkg.sv
      - src/xbus_if.sv
      - src/io_port_decode.sv
      - src/mem_bank_decode.sv
      - src/dma_page_regs.sv
      - src/nmi_control.sv
      - src/pc_glue_top.sv
  - target: test
    files:
      - dv/tb_clk_gen.sv
      - dv/pc_glue_asserts.sv
      - dv/tb_pc_glue.sv

// ==== dv/pc_glue_asserts.sv ====
/* concurrent checks on the glue top level, attached by the bind at the bottom */
`timescale 1ns/1ps

module pc_glue_asserts (
   input logic                               clk,
   input logic                               reset_n,
   input logic [3:0]                         io_cs_n_i,
   input logic [pc_board_pkg::NUM_BANKS-1:0] ras_n_i,
   input logic [pc_board_pkg::NUM_BANKS-1:0] cas_n_i,
   input logic                               nmi_i,
   input logic                               mask_i
);

   // one peripheral selected at a time
   cs_onehot: assert property (@(posedge clk) disable iff (!reset_n) $onehot0(~io_cs_n_i))
      else $error("more than one I/O chip select low");

   for (genvar b = 0; b < pc_board_pkg::NUM_BANKS; b++) begin : g_bank
      cas_after_ras: assert property (@(posedge clk) disable iff (!reset_n)
         !cas_n_i[b] |-> $past(!ras_n_i[b]))
         else $error("CAS low on bank %0d without RAS the cycle before", b);
   end

   nmi_masked: assert property (@(posedge clk) disable iff (!reset_n) !mask_i |-> !nmi_i)
      else $error("NMI raised while the mask is clear");

endmodule

bind pc_glue_top pc_glue_asserts i_asserts (
   .clk       (clk),
   .reset_n   (reset_n),
   .io_cs_n_i (io_cs_n_o),
   .ras_n_i   (ras_n_o),
   .cas_n_i   (cas_n_o),
   .nmi_i     (nmi_o),
   .mask_i    (i_nmi.mask_q)
);

// ==== dv/tb_clk_gen.sv ====
/* testbench clock and reset: 10 ns clock, reset low for the first 10 cycles */
`timescale 1ns/1ps

module tb_clk_gen (
   output logic clk_o,
   output logic reset_n_o
);

   initial begin
      clk_o     = 1'b0;
      reset_n_o = 1'b0;
      repeat (10) @(posedge clk_o);
      reset_n_o <= 1'b1;   // released on an edge like the other inputs
   end

   always #5 clk_o = ~clk_o;

endmodule

// ==== dv/tb_pc_glue.sv ====
/* directed tests for the board glue top level: I/O and memory decode,
   refresh, DMA page file and NMI path, one summary line per test */
`timescale 1ns/1ps

module tb_pc_glue;

   logic        clk;
   logic        reset_n;
   logic [19:0] addr;
   logic [7:0]  data;
   logic        ior_n;
   logic        iow_n;
   logic        memr_n;
   logic        memw_n;
   logic        aen;
   logic [3:0]  dack_n;
   logic        io_ch_ck_n;
   logic        parity_err_n;
   logic [3:0]  io_cs_n;
   logic [7:0]  rom_cs_n;
   logic [3:0]  ras_n;
   logic [3:0]  cas_n;
   logic [3:0]  dma_page;
   logic        nmi;
   logic        io_ch_ck;
   logic [3:0]  page_model [4];
   int          errors;
   int          err_base;
   int          checks;
   int          tests;
   bit          timed_out;

   tb_clk_gen i_clk_gen (.clk_o(clk), .reset_n_o(reset_n));

   pc_glue_top i_dut (
      .clk(clk), .reset_n(reset_n), .addr_i(addr), .data_i(data),
      .ior_n_i(ior_n), .iow_n_i(iow_n), .memr_n_i(memr_n), .memw_n_i(memw_n),
      .aen_i(aen), .dack_n_i(dack_n), .io_ch_ck_n_i(io_ch_ck_n),
      .parity_err_n_i(parity_err_n), .io_cs_n_o(io_cs_n), .rom_cs_n_o(rom_cs_n),
      .ras_n_o(ras_n), .cas_n_o(cas_n), .dma_page_o(dma_page), .nmi_o(nmi),
      .io_ch_ck_o(io_ch_ck)
   );

   task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("[FAIL] %s: expected %0h, actual %0h", name, exp, act);
      end
   endtask

   task automatic end_test(input string name);
      tests++;
      $display("%s finished, %0d errors", name, errors - err_base);
      err_base = errors;
   endtask

   task automatic wait_reset(output bit expired);
      int n;
      for (n = 0; n < 100 && reset_n !== 1'b1; n++) @(negedge clk);
      expired = (reset_n !== 1'b1);
   endtask

   task automatic io_write(input logic [19:0] a, input logic [7:0] d);
      @(posedge clk);
      addr  <= a;
      data  <= d;
      iow_n <= 1'b0;
      @(posedge clk);
      iow_n <= 1'b1;
      @(negedge clk);
   endtask

   task automatic io_decode_sweep();
      logic [3:0] exp;
      for (int a = 0; a < 2; a++) begin
         for (int s = 0; s < 8; s++) begin
            @(posedge clk);
            addr <= {10'h000, 2'b00, 3'(s), 5'($urandom)};
            aen  <= a[0];
            @(negedge clk);
            exp = 4'hF;
            if (a == 0 && s < 4) exp[s] = 1'b0;   // only the four peripheral slots
            compare("io_decode", exp, io_cs_n);
         end
      end
      for (int hi = 1; hi < 4; hi++) begin
         @(posedge clk);
         addr <= {10'h000, 2'(hi), 3'd0, 5'd0};
         aen  <= 1'b0;
         @(negedge clk);
         compare("io_decode_high", 4'hF, io_cs_n);
      end
      end_test("io_decode_sweep");
   endtask

   task automatic mem_decode();
      for (int c = 0; c < 8; c++) begin
         @(posedge clk);
         addr   <= {4'hF, 3'(c), 13'($urandom)};
         memr_n <= 1'b0;
         @(negedge clk);
         compare("rom_select", 8'(~(8'h01 << c)), rom_cs_n);
         compare("rom_no_ras", 4'hF, ras_n);
      end
      for (int b = 0; b < 4; b++) begin
         @(posedge clk);
         addr   <= {2'b00, 2'(b), 16'($urandom)};
         memr_n <= b[0];
         memw_n <= ~b[0];   // odd banks are written
         @(negedge clk);
         compare("ram_ras", 4'(~(4'h1 << b)), ras_n);
         compare("ram_cas_wait", 4'hF, cas_n);
         @(negedge clk);
         compare("ram_cas", 4'(~(4'h1 << b)), cas_n);
         @(posedge clk);
         memr_n <= 1'b1;
         memw_n <= 1'b1;
         @(negedge clk);
         compare("ram_ras_off", 4'hF, ras_n);
         compare("ram_cas_hold", 4'(~(4'h1 << b)), cas_n);
         @(negedge clk);
         compare("ram_cas_off", 4'hF, cas_n);
      end
      @(posedge clk);
      addr   <= 20'h5_1234;   // above RAM, below the ROM segment
      memr_n <= 1'b0;
      @(negedge clk);
      compare("unmapped_rom", 8'hFF, rom_cs_n);
      compare("unmapped_ras", 4'hF, ras_n);
      @(posedge clk);
      memr_n <= 1'b1;
      end_test("mem_decode");
   endtask

   task automatic refresh_cycle();
      @(posedge clk);
      addr   <= 20'($urandom);
      dack_n <= 4'hE;
      memr_n <= 1'b0;
      repeat (3) begin
         @(negedge clk);
         compare("refresh_ras", 4'h0, ras_n);
         compare("refresh_cas", 4'hF, cas_n);
      end
      @(posedge clk);
      memr_n <= 1'b1;
      dack_n <= 4'hF;
      end_test("refresh_cycle");
   endtask

   task automatic read_page(input logic [3:0] acks, input int entry);
      @(posedge clk);
      dack_n <= acks;
      @(negedge clk);
      compare("page_read", page_model[entry], dma_page);
   endtask

   task automatic page_file();
      logic [3:0] val;
      int         idx;
      for (idx = 1; idx < 4; idx++) begin
         val = 4'(idx * 5 + 2);
         io_write({12'h000, 3'd4, 3'd0, 2'(idx)}, {4'h0, val});
         page_model[idx] = val;
      end
      read_page(4'b1011, 1);   // channel 2 active
      read_page(4'b0111, 2);   // channel 3 active
      read_page(4'b1111, 3);
      for (int k = 0; k < 8; k++) begin
         idx = $urandom % 4;
         val = 4'($urandom);
         io_write({12'h000, 3'd4, 3'd0, 2'(idx)}, {4'($urandom), val});
         page_model[idx] = val;
         read_page({idx[0], idx[1], 2'b11}, idx);
      end
      end_test("page_file");
   endtask

   task automatic nmi_path();
      compare("nmi_reset", 1'b0, nmi);
      compare("chck_reset", 1'b0, io_ch_ck);
      @(posedge clk);
      parity_err_n <= 1'b0;
      @(negedge clk);
      compare("parity_masked", 1'b0, nmi);
      io_write(20'h000A0, 8'h80);   // mask set
      compare("parity_nmi", 1'b1, nmi);
      @(posedge clk);
      parity_err_n <= 1'b1;
      @(posedge clk);
      io_ch_ck_n <= 1'b0;
      @(negedge clk);
      compare("chck_early", 1'b0, nmi);
      @(posedge clk);
      io_ch_ck_n <= 1'b1;
      @(negedge clk);
      compare("chck_latch", 1'b1, io_ch_ck);
      compare("chck_nmi", 1'b1, nmi);
      io_write(20'h000A0, 8'h80);   // rearm with the mask kept set
      compare("chck_cleared", 1'b0, io_ch_ck);
      compare("nmi_cleared", 1'b0, nmi);
      io_write(20'h000A0, 8'h00);
      end_test("nmi_path");
   endtask

   initial begin
      void'($urandom(32'h67cd));
      addr         = '0;
      data         = '0;
      ior_n        = 1'b1;
      iow_n        = 1'b1;
      memr_n       = 1'b1;
      memw_n       = 1'b1;
      aen          = 1'b0;
      dack_n       = 4'hF;
      io_ch_ck_n   = 1'b1;
      parity_err_n = 1'b1;
      page_model   = '{default: 4'h0};
      wait_reset(timed_out);
      if (timed_out) begin
         $display("timeout: reset was never released");
         errors++;
      end else begin
         nmi_path();
         io_decode_sweep();
         mem_decode();
         refresh_cycle();
         page_file();
      end
      $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
      if (errors == 0) $display("Verification passed");
      else $display("Verification failed");
      $finish;
   end

endmodule

// ==== sources.f ====
src/pc_board_pkg.sv
src/xbus_if.sv
src/io_port_decode.sv
src/mem_bank_decode.sv
src/dma_page_regs.sv
src/nmi_control.sv
src/pc_glue_top.sv
dv/tb_clk_gen.sv
dv/pc_glue_asserts.sv
dv/tb_pc_glue.sv

// ==== src/dma_page_regs.sv ====
/* four-entry DMA page register file, written through the page port and
   read out by the active DMA acknowledge as the upper address nibble */
`timescale 1ns/1ps

module dma_page_regs (
   input  logic                             clk,
   input  logic                             reset_n,
   xbus_if.regs                             bus,
   input  logic                             page_wr_n_i,
   output logic [pc_board_pkg::PAGE_W-1:0]  dma_page_o
);

   localparam int IDX_W = $clog2(pc_board_pkg::NUM_DMA_CH);

   logic [pc_board_pkg::PAGE_W-1:0] page_q [pc_board_pkg::NUM_DMA_CH];
   logic [IDX_W-1:0]                wr_idx;
   logic [IDX_W-1:0]                rd_idx;

   assign wr_idx = bus.addr[IDX_W-1:0];   // A1..A0

   // ack lines wired straight to the read select, as on the 670 file
   // ch2 -> entry 1, ch3 -> entry 2, idle -> entry 3
   assign rd_idx = {bus.dack_n[2], bus.dack_n[3]};

   // held write strobe just rewrites the same entry
   always_ff @(posedge clk) begin
      if (!reset_n) begin
         for (int i = 0; i < pc_board_pkg::NUM_DMA_CH; i++) begin
            page_q[i] <= '0;
         end
      end else if (!page_wr_n_i) begin
         page_q[wr_idx] <= bus.data[pc_board_pkg::PAGE_W-1:0];
      end
   end

   assign dma_page_o = page_q[rd_idx];

endmodule

// ==== src/io_port_decode.sv ====
/* low I/O port decoder: peripheral chip selects plus the page and NMI mask
   write strobes, purely combinational from address, aen and iow_n */
`timescale 1ns/1ps

module io_port_decode (
   xbus_if.decode     bus,
   output logic [3:0] io_cs_n_o,     // DMA, interrupt ctrl, timer, PPI
   output logic       page_wr_n_o,
   output logic       nmi_wr_n_o
);

   pc_board_pkg::io_sel_e slot;
   logic                  io_en;

   // ports 000h..0FFh only, and not during a DMA cycle
   assign io_en = ~bus.aen & (bus.addr[9:8] == 2'b00);
   assign slot  = pc_board_pkg::io_sel_e'(bus.addr[7:5]);

   // 3-to-8 decode over A7..A5
   always_comb begin
      io_cs_n_o   = 4'b1111;
      page_wr_n_o = 1'b1;
      nmi_wr_n_o  = 1'b1;
      if (io_en) begin
         case (slot)
            pc_board_pkg::IO_DMA: begin
               io_cs_n_o[0] = 1'b0;
            end
            pc_board_pkg::IO_INTR: begin
               io_cs_n_o[1] = 1'b0;
            end
            pc_board_pkg::IO_TIMER: begin
               io_cs_n_o[2] = 1'b0;
            end
            pc_board_pkg::IO_PPI: begin
               io_cs_n_o[3] = 1'b0;
            end
            pc_board_pkg::IO_DMA_PAGE: begin
               page_wr_n_o = bus.iow_n;   // write only
            end
            pc_board_pkg::IO_NMI_MASK: begin
               nmi_wr_n_o = bus.iow_n;    // write only
            end
            pc_board_pkg::IO_SPARE0,
            pc_board_pkg::IO_SPARE1: begin
               io_cs_n_o = 4'b1111;       // nothing fitted
            end
            default: begin
               io_cs_n_o = 4'b1111;
            end
         endcase
      end
   end

endmodule

// ==== src/mem_bank_decode.sv ====
/* ROM socket selects and RAS/CAS for the four RAM banks, including DMA
   channel 0 refresh; CAS is a registered copy of RAS one clock later */
`timescale 1ns/1ps

module mem_bank_decode #(
   parameter logic [3:0] ROM_SEG = pc_board_pkg::ROM_SEG_DEFAULT
) (
   input  logic                                clk,
   input  logic                                reset_n,
   xbus_if.decode                              bus,
   output logic [pc_board_pkg::ROM_CHIPS-1:0]  rom_cs_n_o,
   output logic [pc_board_pkg::NUM_BANKS-1:0]  ras_n_o,
   output logic [pc_board_pkg::NUM_BANKS-1:0]  cas_n_o
);

   localparam int ROM_IDX_W  = $clog2(pc_board_pkg::ROM_CHIPS);
   localparam int BANK_IDX_W = $clog2(pc_board_pkg::NUM_BANKS);
   localparam int SEG_LSB    = pc_board_pkg::ADDR_W - 4;   // A16

   logic                  mem_cyc;
   logic                  refresh;
   logic                  rom_hit;
   logic                  ram_hit;
   logic [ROM_IDX_W-1:0]  rom_idx;
   logic [BANK_IDX_W-1:0] bank_idx;

   assign mem_cyc = ~bus.memr_n | ~bus.memw_n;

   // refresh is a DMA ch0 memory read
   assign refresh = ~bus.dack_n[0] & ~bus.memr_n;

   assign rom_hit = (bus.addr[pc_board_pkg::ADDR_W-1:SEG_LSB] == ROM_SEG) & ~bus.memr_n;
   assign rom_idx = bus.addr[SEG_LSB-1 -: ROM_IDX_W];   // A15..A13

   // lower 256K, normal CPU or DMA cycle
   assign ram_hit  = (bus.addr[pc_board_pkg::ADDR_W-1:pc_board_pkg::RAM_TOP_BIT] == '0)
                     & bus.dack_n[0] & mem_cyc;
   assign bank_idx = bus.addr[pc_board_pkg::RAM_TOP_BIT-1 -: BANK_IDX_W];   // A17..A16

   always_comb begin
      rom_cs_n_o = '1;
      if (rom_hit) begin
         rom_cs_n_o[rom_idx] = 1'b0;
      end
   end

   // refresh strobes every bank at once, address ignored
   always_comb begin
      ras_n_o = '1;
      if (refresh) begin
         ras_n_o = '0;
      end else if (ram_hit) begin
         ras_n_o[bank_idx] = 1'b0;
      end
   end

   // stands in for the delay line tap; RAS-only during refresh
   always_ff @(posedge clk) begin
      if (!reset_n) begin
         cas_n_o <= '1;
      end else begin
         cas_n_o <= ras_n_o | {pc_board_pkg::NUM_BANKS{refresh}};
      end
   end

endmodule

// ==== src/nmi_control.sv ====
/* NMI enable mask, I/O channel check latch and the final NMI combine
   with the active-low parity error input */
`timescale 1ns/1ps

module nmi_control (
   input  logic  clk,
   input  logic  reset_n,
   xbus_if.nmi   bus,
   input  logic  nmi_wr_n_i,
   input  logic  io_ch_ck_n_i,
   input  logic  parity_err_n_i,
   output logic  nmi_o,
   output logic  io_ch_ck_o
);

   logic mask_q;   // D7 of the last mask write
   logic chck_q;   // sticky channel check

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         mask_q <= 1'b0;
      end else if (!nmi_wr_n_i) begin
         mask_q <= bus.data[7];
      end
   end

   // a mask write rearms the latch; a pin still held low wins
   always_ff @(posedge clk) begin
      if (!reset_n) begin
         chck_q <= 1'b0;
      end else if (!io_ch_ck_n_i) begin
         chck_q <= 1'b1;
      end else if (!nmi_wr_n_i) begin
         chck_q <= 1'b0;
      end
   end

   assign io_ch_ck_o = chck_q;

   // parity goes straight through, channel check via the latch
   assign nmi_o = mask_q & (chck_q | ~parity_err_n_i);

endmodule

// ==== src/pc_board_pkg.sv ====
/* shared widths, decode constants and the I/O slot enum for the board glue logic,
   referenced by scoped name from the interface and every RTL module */
package pc_board_pkg;

   // system bus
   localparam int ADDR_W = 20;
   localparam int DATA_W = 8;

   // memory map
   localparam int NUM_BANKS   = 4;     // 64K RAM banks
   localparam int ROM_CHIPS   = 8;     // 8K ROM sockets
   localparam int RAM_TOP_BIT = 18;    // first bit above the 256K RAM region

   // ROM window, top address nibble
   localparam logic [3:0] ROM_SEG_DEFAULT = 4'hF;

   // DMA channels, also the ack bus width and page file depth
   localparam int NUM_DMA_CH = 4;
   localparam int PAGE_W     = 4;      // A19..A16 of a DMA cycle

   // I/O decode slots, selected by address bits 7..5
   typedef enum logic [2:0] {
      IO_DMA      = 3'd0,   // 8237 DMA controller
      IO_INTR     = 3'd1,   // 8259 interrupt controller
      IO_TIMER    = 3'd2,   // 8253 timer
      IO_PPI      = 3'd3,   // 8255 parallel port
      IO_DMA_PAGE = 3'd4,   // page register write
      IO_NMI_MASK = 3'd5,   // NMI mask write
      IO_SPARE0   = 3'd6,
      IO_SPARE1   = 3'd7
   } io_sel_e;

endpackage

// ==== src/pc_glue_top.sv ====
/* system-board glue top level: pins in, bus bundle out to the I/O decode,
   memory decode, DMA page file and NMI blocks */
`timescale 1ns/1ps

module pc_glue_top #(
   parameter logic [3:0] ROM_SEG = pc_board_pkg::ROM_SEG_DEFAULT
) (
   input  logic                                 clk,
   input  logic                                 reset_n,
   input  logic [pc_board_pkg::ADDR_W-1:0]      addr_i,
   input  logic [pc_board_pkg::DATA_W-1:0]      data_i,
   input  logic                                 ior_n_i,
   input  logic                                 iow_n_i,
   input  logic                                 memr_n_i,
   input  logic                                 memw_n_i,
   input  logic                                 aen_i,
   input  logic [pc_board_pkg::NUM_DMA_CH-1:0]  dack_n_i,
   input  logic                                 io_ch_ck_n_i,
   input  logic                                 parity_err_n_i,
   output logic [3:0]                           io_cs_n_o,   // DMA, intr, timer, PPI
   output logic [pc_board_pkg::ROM_CHIPS-1:0]   rom_cs_n_o,
   output logic [pc_board_pkg::NUM_BANKS-1:0]   ras_n_o,
   output logic [pc_board_pkg::NUM_BANKS-1:0]   cas_n_o,
   output logic [pc_board_pkg::PAGE_W-1:0]      dma_page_o,
   output logic                                 nmi_o,
   output logic                                 io_ch_ck_o
);

   logic page_wr_n;   // io decode -> page file
   logic nmi_wr_n;    // io decode -> NMI mask

   xbus_if bus ();

   assign bus.addr   = addr_i;
   assign bus.data   = data_i;
   assign bus.ior_n  = ior_n_i;
   assign bus.iow_n  = iow_n_i;
   assign bus.memr_n = memr_n_i;
   assign bus.memw_n = memw_n_i;
   assign bus.aen    = aen_i;
   assign bus.dack_n = dack_n_i;

   io_port_decode i_io_dec (
      .bus         (bus.decode),
      .io_cs_n_o   (io_cs_n_o),
      .page_wr_n_o (page_wr_n),
      .nmi_wr_n_o  (nmi_wr_n)
   );

   mem_bank_decode #(
      .ROM_SEG (ROM_SEG)
   ) i_mem_dec (
      .clk        (clk),
      .reset_n    (reset_n),
      .bus        (bus.decode),
      .rom_cs_n_o (rom_cs_n_o),
      .ras_n_o    (ras_n_o),
      .cas_n_o    (cas_n_o)
   );

   dma_page_regs i_page (
      .clk         (clk),
      .reset_n     (reset_n),
      .bus         (bus.regs),
      .page_wr_n_i (page_wr_n),
      .dma_page_o  (dma_page_o)
   );

   nmi_control i_nmi (
      .clk            (clk),
      .reset_n        (reset_n),
      .bus            (bus.nmi),
      .nmi_wr_n_i     (nmi_wr_n),
      .io_ch_ck_n_i   (io_ch_ck_n_i),
      .parity_err_n_i (parity_err_n_i),
      .nmi_o          (nmi_o),
      .io_ch_ck_o     (io_ch_ck_o)
   );

endmodule

// ==== src/xbus_if.sv ====
/* buffered system-board bus, driven by the top level from its input pins
   and read by the decode, register and NMI blocks through their modports */
`timescale 1ns/1ps

interface xbus_if;

   logic [pc_board_pkg::ADDR_W-1:0]     addr;
   logic [pc_board_pkg::DATA_W-1:0]     data;

   // command strobes, all active low
   logic                                ior_n;
   logic                                iow_n;
   logic                                memr_n;
   logic                                memw_n;

   logic                                aen;      // high while DMA owns the bus
   logic [pc_board_pkg::NUM_DMA_CH-1:0] dack_n;   // DMA acknowledges

   // address and memory decode
   modport decode (input addr, ior_n, iow_n, memr_n, memw_n, aen, dack_n);

   // DMA page register file
   modport regs (input addr, data, dack_n);

   // NMI mask register
   modport nmi (input data);

endinterface
